// ==== logic/i2s_pkg.sv ====
package i2s_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// One channel sample
	localparam int SAMPLE_W = 16;
	// Stored stereo frame, left in the upper half
	localparam int FRAME_W = 2 * SAMPLE_W;
	// Frames held in the sample RAM
	localparam int RAM_DEPTH = 16;
	localparam int ADDR_W = $clog2(RAM_DEPTH);

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// RAM data word
	// Left is declared first so it lands in the MSBs and goes out first
	typedef struct packed {
		logic [SAMPLE_W-1:0] left;
		logic [SAMPLE_W-1:0] right;
	} frame_t;

	// Receiver FSM
	typedef enum logic {
		RX_IDLE,
		RX_ACTIVE
	} rx_state_t;

	// Transmitter FSM
	typedef enum logic {
		TX_IDLE,
		TX_ACTIVE
	} tx_state_t;

	// Access type on the shared RAM port
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} bus_op_t;

endpackage

// ==== logic/sample_bus_if.sv ====
interface sample_bus_if import i2s_pkg::*; ();

	// Requester side
	logic req;
	bus_op_t op;
	logic [ADDR_W-1:0] addr;
	frame_t wdata;

	// Arbiter side
	logic gnt;
	// Valid one clk after the gnt cycle
	frame_t rdata;

	// Peer that wants the RAM
	modport requester (
		output req,
		output op,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	// Arbiter view of one peer
	modport arbiter (
		input  req,
		input  op,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

// ==== logic/i2s_line_sampler.sv ====
module i2s_line_sampler (
	input  logic clk,
	input  logic rst,
	input  logic sck,
	input  logic ws,
	input  logic sd,
	output logic sck_rise,
	output logic sck_fall,
	output logic ws_fall,
	output logic ws_sync,
	output logic sd_sync
);

	// Delay chains, [0] is first stage off the pin
	logic [2:0] sck_d;
	logic [2:0] ws_d;
	logic [2:0] sd_d;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sck_d <= '0;
			ws_d <= '0;
			sd_d <= '0;
			sck_rise <= 1'b0;
			sck_fall <= 1'b0;
			ws_fall <= 1'b0;
		end
		else
		begin
			sck_d <= {sck_d[1:0], sck};
			ws_d <= {ws_d[1:0], ws};
			sd_d <= {sd_d[1:0], sd};
			// Strobes registered so they line up with stage 2 below
			sck_rise <= sck_d[1] & ~sck_d[2];
			sck_fall <= ~sck_d[1] & sck_d[2];
			// Right to left transition marks a new frame
			ws_fall <= ~ws_d[1] & ws_d[2];
		end
	end

	// Same 3 clk latency as the strobes
	assign ws_sync = ws_d[2];
	assign sd_sync = sd_d[2];

	// A half period spans at least 8 clk
	a_sck_spacing: assert property (@(posedge clk) disable iff (!rst)
		(sck_rise || sck_fall) |=> !(sck_rise || sck_fall) [*7])
		else $error("sck edge strobes come too close");

endmodule

// ==== logic/i2s_deserializer.sv ====
module i2s_deserializer import i2s_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic rx_en,
	input  logic sck_rise,
	input  logic ws_fall,
	input  logic ws_sync,
	input  logic sd_sync,
	output logic [SAMPLE_W-1:0] rx_left,
	output logic [SAMPLE_W-1:0] rx_right,
	output logic rx_done,
	sample_bus_if.requester bus
);

	rx_state_t state;
	// ws one bit late, selects the channel of the current bit
	logic ws_bit;
	logic [SAMPLE_W-1:0] left_sr;
	logic [SAMPLE_W-1:0] right_sr;
	frame_t done_frame;
	frame_t wr_buf;
	logic [ADDR_W-1:0] wr_ptr;
	logic req;
	logic frame_end;

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= RX_IDLE;
		else if (!rx_en)
			state <= RX_IDLE;
		else if (ws_fall)
			state <= RX_ACTIVE;
	end

	// First ws_fall only arms, later ones close a frame
	assign frame_end = ws_fall && (state == RX_ACTIVE);

	////////////////////////////////////////
	// Shifting
	////////////////////////////////////////

	// Tracked in idle too, so the first active bit is routed right
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			ws_bit <= 1'b0;
		else if (sck_rise)
			ws_bit <= ws_sync;
	end

	always_ff @(posedge clk)
	begin
		if (sck_rise && (state == RX_ACTIVE))
		begin
			if (!ws_bit)
				left_sr <= {left_sr[SAMPLE_W-2:0], sd_sync};
			else
				right_sr <= {right_sr[SAMPLE_W-2:0], sd_sync};
		end
	end

	// Right LSB sits on sd already at ws_fall since ws and sd move together
	assign done_frame.left = left_sr;
	assign done_frame.right = {right_sr[SAMPLE_W-2:0], sd_sync};

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rx_left <= '0;
			rx_right <= '0;
			rx_done <= 1'b0;
		end
		else
		begin
			rx_done <= frame_end;
			if (frame_end)
			begin
				rx_left <= done_frame.left;
				rx_right <= done_frame.right;
			end
		end
	end

	////////////////////////////////////////
	// RAM write
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (frame_end)
			wr_buf <= done_frame;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			req <= 1'b0;
			wr_ptr <= '0;
		end
		else
		begin
			// Write done in the gnt cycle
			if (req && bus.gnt)
			begin
				req <= 1'b0;
				wr_ptr <= (wr_ptr == ADDR_W'(RAM_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (frame_end)
				req <= 1'b1;
		end
	end

	assign bus.req = req;
	assign bus.op = OP_WRITE;
	assign bus.addr = wr_ptr;
	assign bus.wdata = wr_buf;

	// Previous write must be granted before the next frame closes
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst)
		frame_end |-> (!req || bus.gnt))
		else $error("frame end while RAM write still pending");

endmodule

// ==== logic/i2s_serializer.sv ====
module i2s_serializer import i2s_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic play_en,
	input  logic sck_fall,
	input  logic ws_fall,
	output logic sd_out,
	sample_bus_if.requester bus
);

	tx_state_t state;
	logic [FRAME_W-1:0] shreg;
	frame_t next_buf;
	// Set once a fetched frame sits in next_buf
	logic buf_valid;
	logic [ADDR_W-1:0] rd_ptr;
	logic req;
	// rdata arrives this cycle
	logic rd_pend;
	logic frame_start;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= TX_IDLE;
		else if (!play_en)
			state <= TX_IDLE;
		else if (ws_fall)
			state <= TX_ACTIVE;
	end

	assign frame_start = ws_fall && (state == TX_ACTIVE);

	////////////////////////////////////////
	// Output shifter
	////////////////////////////////////////

	// ws_fall trails sck_fall by a clk, so the right LSB is out before reload
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			shreg <= '0;
			sd_out <= 1'b0;
		end
		else if (state == TX_IDLE)
		begin
			shreg <= '0;
			if (sck_fall)
				sd_out <= 1'b0;
		end
		else if (frame_start)
			shreg <= buf_valid ? next_buf : '0;
		else if (sck_fall)
		begin
			sd_out <= shreg[FRAME_W-1];
			shreg <= {shreg[FRAME_W-2:0], 1'b0};
		end
	end

	////////////////////////////////////////
	// Frame fetch
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			req <= 1'b0;
			rd_ptr <= '0;
			rd_pend <= 1'b0;
			buf_valid <= 1'b0;
		end
		else
		begin
			rd_pend <= req && bus.gnt;
			if (req && bus.gnt)
			begin
				req <= 1'b0;
				rd_ptr <= (rd_ptr == ADDR_W'(RAM_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			else if (frame_start)
				req <= 1'b1;
			if (rd_pend)
				buf_valid <= 1'b1;
			else if (state == TX_IDLE)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_pend)
			next_buf <= bus.rdata;
	end

	assign bus.req = req;
	assign bus.op = OP_READ;
	assign bus.addr = rd_ptr;
	assign bus.wdata = '0;

	// Previous fetch must have landed in next_buf before the reload
	a_fetch_done: assert property (@(posedge clk) disable iff (!rst)
		frame_start |-> !(req || rd_pend))
		else $error("frame start while the previous read is still pending");

endmodule

// ==== logic/sample_bus_arbiter.sv ====
module sample_bus_arbiter import i2s_pkg::*; (
	input  logic clk,
	input  logic rst,
	sample_bus_if.arbiter rx_bus,
	sample_bus_if.arbiter tx_bus,
	output logic [ADDR_W-1:0] ram_addr,
	output frame_t ram_wdata,
	output logic ram_we,
	input  frame_t ram_rdata
);

	logic rx_win;
	logic tx_win;

	////////////////////////////////////////
	// Grant
	////////////////////////////////////////

	// Receiver first, so a same-edge read sees the fresh frame
	assign rx_win = rx_bus.req;
	assign tx_win = tx_bus.req && !rx_bus.req;

	assign rx_bus.gnt = rx_win;
	assign tx_bus.gnt = tx_win;

	////////////////////////////////////////
	// RAM port mux
	////////////////////////////////////////

	assign ram_addr = rx_win ? rx_bus.addr : tx_bus.addr;
	assign ram_wdata = rx_win ? rx_bus.wdata : tx_bus.wdata;
	assign ram_we = (rx_win && (rx_bus.op == OP_WRITE)) ||
		(tx_win && (tx_bus.op == OP_WRITE));

	// Read data fans out, each peer knows when it is its own
	assign rx_bus.rdata = ram_rdata;
	assign tx_bus.rdata = ram_rdata;

	// Receiver holds the port for one clk only, so the transmitter waits at most one
	a_tx_wait: assert property (@(posedge clk) disable iff (!rst)
		(tx_bus.req && !tx_bus.gnt) |=> tx_bus.gnt)
		else $error("transmitter kept waiting past one cycle");

endmodule

// ==== logic/sample_ram.sv ====
module sample_ram import i2s_pkg::*; (
	input  logic clk,
	input  logic [ADDR_W-1:0] addr,
	input  frame_t wdata,
	input  logic we,
	output frame_t rdata
);

	// One stereo frame per entry
	frame_t mem [RAM_DEPTH];

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// ==== logic/i2s_loopback_top.sv ====
module i2s_loopback_top import i2s_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic sck,
	input  logic ws,
	input  logic sd_in,
	input  logic rx_en,
	input  logic play_en,
	output logic [SAMPLE_W-1:0] rx_left,
	output logic [SAMPLE_W-1:0] rx_right,
	output logic rx_done,
	output logic sd_out
);

	// Sampler outputs, shared by both peers
	logic sck_rise;
	logic sck_fall;
	logic ws_fall;
	logic ws_sync;
	logic sd_sync;

	// RAM port
	logic [ADDR_W-1:0] ram_addr;
	frame_t ram_wdata;
	frame_t ram_rdata;
	logic ram_we;

	sample_bus_if rx_bus ();
	sample_bus_if tx_bus ();

	i2s_line_sampler i_sampler (
		.clk      (clk),
		.rst      (rst),
		.sck      (sck),
		.ws       (ws),
		.sd       (sd_in),
		.sck_rise (sck_rise),
		.sck_fall (sck_fall),
		.ws_fall  (ws_fall),
		.ws_sync  (ws_sync),
		.sd_sync  (sd_sync)
	);

	i2s_deserializer i_rx (
		.clk      (clk),
		.rst      (rst),
		.rx_en    (rx_en),
		.sck_rise (sck_rise),
		.ws_fall  (ws_fall),
		.ws_sync  (ws_sync),
		.sd_sync  (sd_sync),
		.rx_left  (rx_left),
		.rx_right (rx_right),
		.rx_done  (rx_done),
		.bus      (rx_bus.requester)
	);

	i2s_serializer i_tx (
		.clk      (clk),
		.rst      (rst),
		.play_en  (play_en),
		.sck_fall (sck_fall),
		.ws_fall  (ws_fall),
		.sd_out   (sd_out),
		.bus      (tx_bus.requester)
	);

	sample_bus_arbiter i_arb (
		.clk       (clk),
		.rst       (rst),
		.rx_bus    (rx_bus.arbiter),
		.tx_bus    (tx_bus.arbiter),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.ram_rdata (ram_rdata)
	);

	sample_ram i_ram (
		.clk   (clk),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.we    (ram_we),
		.rdata (ram_rdata)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// 20 time unit period
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 10;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Active low reset, released shortly after a rising edge
	initial
	begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst = 1'b1;
	end

endmodule

// ==== testbench/tb_i2s_loopback.sv ====
module tb_i2s_loopback import i2s_pkg::*; ();

	// Inputs change this long after a rising clk edge
	localparam int DRIVE_DLY = 2;
	// sck half period in clk
	localparam int HALF_SCK = 8;
	localparam int FRAME_CLK = 2 * HALF_SCK * FRAME_W;
	localparam int RUN_FRAMES = 24;
	localparam int NUM_TESTS = 5;

	logic clk;
	logic rst;
	logic sck;
	logic ws;
	logic sd_in;
	logic rx_en;
	logic play_en;
	logic [SAMPLE_W-1:0] rx_left;
	logic [SAMPLE_W-1:0] rx_right;
	logic rx_done;
	logic sd_out;

	// Master model and decoder state
	logic [31:0] rng;
	logic [FRAME_W-1:0] sent_q [$];
	logic [FRAME_W-1:0] out_acc;
	int frame_no;
	bit master_go;
	bit lb_on;
	bit rx_quiet;
	bit timed_out;
	int rx_count;
	int lb_count;
	int wrap_count;
	// Test that owns the receiver checks right now
	int cur_rx_test;
	int test_errs [NUM_TESTS];
	string test_name [NUM_TESTS];

	tb_clock_gen i_clk (
		.clk (clk),
		.rst (rst)
	);

	i2s_loopback_top i_dut (
		.clk      (clk),
		.rst      (rst),
		.sck      (sck),
		.ws       (ws),
		.sd_in    (sd_in),
		.rx_en    (rx_en),
		.play_en  (play_en),
		.rx_left  (rx_left),
		.rx_right (rx_right),
		.rx_done  (rx_done),
		.sd_out   (sd_out)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// 32-bit xorshift, never returns zero for a nonzero seed
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input int id, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name[id], expected, actual);
			test_errs[id]++;
		end
	endtask

	task automatic report_test(input int id);
		if (test_errs[id] == 0)
			$display("test %s: passed", test_name[id]);
		else
			$display("test %s: failed with %0d errors", test_name[id], test_errs[id]);
	endtask

	// Whole frame at the DUT port, so the frame count is the time base
	task automatic wait_until_frame(input int target);
		int limit;
		int n;
		limit = (target - frame_no + 1) * FRAME_CLK;
		n = 0;
		while (frame_no < target && n < limit && !timed_out)
		begin
			@(posedge clk);
			n++;
		end
		if (frame_no < target && !timed_out)
		begin
			$display("timeout: frame %0d never started", target);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_rx_done();
		int ref_count;
		int n;
		ref_count = rx_count;
		n = 0;
		while (rx_count == ref_count && n < 3 * FRAME_CLK && !timed_out)
		begin
			@(posedge clk);
			n++;
		end
		if (rx_count == ref_count && !timed_out)
		begin
			$display("timeout: no rx_done pulse within three frame times");
			timed_out = 1'b1;
		end
	endtask

	////////////////////////////////////////
	// I2S master and sd_out decoder
	////////////////////////////////////////

	// One bit slot: sck falls, ws and sd follow one clk later, sck rises 8 clk after the fall
	task automatic drive_slot(input logic ws_val, input logic sd_val);
		@(posedge clk);
		#DRIVE_DLY sck = 1'b0;
		@(posedge clk);
		#DRIVE_DLY;
		ws = ws_val;
		sd_in = sd_val;
		repeat (HALF_SCK - 1) @(posedge clk);
		#DRIVE_DLY sck = 1'b1;
		// Decoder picks up sd_out on the rising sck
		out_acc = {out_acc[FRAME_W-2:0], sd_out};
		repeat (HALF_SCK - 1) @(posedge clk);
	endtask

	// Output frame k should be input frame k-2, first two silent
	task automatic check_out_frame(input int k);
		logic [FRAME_W-1:0] expected;
		int id;
		expected = (k < 2) ? '0 : sent_q[k-2];
		// Reads past the last RAM entry count toward the wrap test
		id = (k >= RAM_DEPTH + 2) ? 3 : 2;
		check_value(id, expected, out_acc);
		lb_count++;
		if (id == 3)
			wrap_count++;
	endtask

	task automatic run_frame();
		logic [FRAME_W-1:0] cur;
		logic [FRAME_W-1:0] prev;
		int i;
		prev = (sent_q.size() > 0) ? sent_q[$] : '0;
		rng = xorshift(rng);
		cur = rng;
		sent_q.push_back(cur);
		frame_no++;
		// Slot 0: ws falls, sd still carries the right LSB of the frame before
		drive_slot(1'b0, prev[0]);
		if (lb_on && frame_no > 0)
			check_out_frame(frame_no - 1);
		// Left MSB first, right from slot 16 on
		for (i = 1; i < FRAME_W; i++)
			drive_slot(i >= SAMPLE_W, cur[FRAME_W-i]);
	endtask

	initial
	begin
		forever
		begin
			if (master_go)
				run_frame();
			else
				@(posedge clk);
		end
	end

	////////////////////////////////////////
	// Receiver checks
	////////////////////////////////////////

	// Finished frame is the one sent before the current one
	always @(negedge clk)
	begin
		if (rst && rx_done)
		begin
			check_value(cur_rx_test, sent_q[frame_no-1], {rx_left, rx_right});
			rx_count++;
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		rx_done |=> !rx_done)
		else
		begin
			$display("rx_done stayed high for more than one clk");
			test_errs[cur_rx_test]++;
		end

	// Samples only move together with rx_done
	a_rx_hold: assert property (@(posedge clk) disable iff (!rst)
		!rx_done |-> $stable({rx_left, rx_right}))
		else
		begin
			$display("rx_left or rx_right changed without rx_done");
			test_errs[cur_rx_test]++;
		end

	a_rx_quiet: assert property (@(posedge clk) disable iff (!rst)
		rx_quiet |-> !rx_done)
		else
		begin
			$display("rx_done pulsed while the receiver was disabled");
			test_errs[4]++;
		end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int n;
		int i;
		int quiet_ref;
		int en_frame;
		int failed;
		int total;
		test_name[0] = "reset_state";
		test_name[1] = "rx_capture";
		test_name[2] = "loopback_delay";
		test_name[3] = "ram_wrap";
		test_name[4] = "rx_disable";
		sck = 1'b0;
		// Idle on the right channel so frame 0 opens with a ws fall
		ws = 1'b1;
		sd_in = 1'b0;
		rx_en = 1'b0;
		play_en = 1'b0;
		rng = 32'h6c1e;
		out_acc = '0;
		frame_no = -1;
		cur_rx_test = 1;

		// reset_state, during reset and a while after
		n = 0;
		@(negedge clk);
		while (!rst && n < 100)
		begin
			check_value(0, 32'h0, 32'(rx_done));
			check_value(0, 32'h0, 32'(sd_out));
			check_value(0, 32'h0, {rx_left, rx_right});
			@(negedge clk);
			n++;
		end
		if (!rst)
		begin
			$display("timeout: reset never released");
			timed_out = 1'b1;
		end
		for (i = 0; i < 20; i++)
		begin
			check_value(0, 32'h0, 32'(rx_done));
			check_value(0, 32'h0, 32'(sd_out));
			check_value(0, 32'h0, {rx_left, rx_right});
			@(negedge clk);
		end
		report_test(0);

		// Both peers armed before the first ws fall
		@(posedge clk);
		#DRIVE_DLY;
		rx_en = 1'b1;
		play_en = 1'b1;
		lb_on = 1'b1;
		master_go = 1'b1;
		wait_until_frame(RUN_FRAMES);
		// Settle into mid frame, last output frame decoded
		repeat (4 * HALF_SCK) @(posedge clk);
		lb_on = 1'b0;
		check_value(1, RUN_FRAMES, rx_count);
		report_test(1);
		check_value(2, RUN_FRAMES, lb_count);
		report_test(2);
		if (lb_count <= 20 || wrap_count == 0)
		begin
			$display("ram_wrap: only %0d frames looped back, pointers did not wrap", lb_count);
			test_errs[3]++;
		end
		report_test(3);

		// rx_disable
		cur_rx_test = 4;
		#DRIVE_DLY;
		rx_en = 1'b0;
		@(posedge clk);
		#DRIVE_DLY;
		rx_quiet = 1'b1;
		quiet_ref = rx_count;
		wait_until_frame(frame_no + 3);
		repeat (4 * HALF_SCK) @(posedge clk);
		check_value(4, quiet_ref, rx_count);
		#DRIVE_DLY;
		rx_quiet = 1'b0;
		rx_en = 1'b1;
		en_frame = frame_no;
		// Next ws fall arms, the one after closes the first frame
		wait_rx_done();
		check_value(4, en_frame + 2, frame_no);
		wait_rx_done();
		check_value(4, en_frame + 3, frame_no);
		report_test(4);

		failed = 0;
		total = 0;
		for (i = 0; i < NUM_TESTS; i++)
		begin
			if (test_errs[i] != 0)
				failed++;
			total += test_errs[i];
		end
		$display("tests run: %0d, failed: %0d, errors: %0d, timeout: %0d",
			NUM_TESTS, failed, total, timed_out);
		if (failed == 0 && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== project.f ====
logic/i2s_pkg.sv
logic/sample_bus_if.sv
logic/i2s_line_sampler.sv
logic/i2s_deserializer.sv
logic/i2s_serializer.sv
logic/sample_bus_arbiter.sv
logic/sample_ram.sv
logic/i2s_loopback_top.sv
testbench/tb_clock_gen.sv
testbench/tb_i2s_loopback.sv

// ==== Makefile ====
# Verilator build and run for the I2S loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_i2s_loopback
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(BUILD_DIR)
